//--- include/ao_periph_cfg.svh
/* Address map and reset constants of the always-on peripheral subsystem.
   Include wherever the decode or a reset value is needed. */

`ifndef AO_PERIPH_CFG_SVH
`define AO_PERIPH_CFG_SVH

// Upper address bits that select the subsystem
`define AO_BASE_REGION 16'h2000

// Peripheral count behind the bridge
`define AO_NUM_PERIPH 3

// Peripheral indices, address bits [15:12]
`define AO_IDX_SOC_CTRL 4'd0
`define AO_IDX_POWER 4'd1
`define AO_IDX_TIMER 4'd2

// Timer prescale after reset
`define AO_TIMER_PRESCALE_RST 32'd3

// Read data for an access that hits no peripheral
`define AO_DECODE_ERR_DATA 32'hBADCAB1E

`endif

//--- rtl/ao_periph_pkg.sv
/* Bus types shared by the bridge, the peripherals and the testbench.
   Import with a wildcard in the module header. */

package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  be;
    logic [11:0] offset;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Bus address seen as a flat word or as decode fields
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] region;
      logic [3:0]  index;
      logic [11:0] offset;
    } fields;
  } reg_addr_u;

  // Merge a write into a register under its byte enables
  function automatic logic [31:0] apply_be(logic [31:0] old_val, logic [31:0] new_val,
                                           logic [3:0] be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b+:8] = new_val[8*b+:8];
      end
    end
    return res;
  endfunction

endpackage

//--- rtl/obi_reg_bridge.sv
/* OBI slave to single-cycle register bus with address decode and demux.
   Grants every request at once and returns the response one cycle later. */

`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module obi_reg_bridge
  import ao_periph_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  obi_req_t                      obi_req_i,
  output obi_resp_t                     obi_resp_o,
  output reg_req_t [`AO_NUM_PERIPH-1:0] reg_req_o,
  input  reg_rsp_t [`AO_NUM_PERIPH-1:0] reg_rsp_i
);

  reg_addr_u                 addr_view;
  logic                      hit;
  logic [`AO_NUM_PERIPH-1:0] valid_vec;
  reg_rsp_t                  sel_rsp;
  logic [31:0]               rdata_d;
  logic                      rvalid_q;
  logic [31:0]               rdata_q;

  assign addr_view.word = obi_req_i.addr;
  assign hit = (addr_view.fields.region == `AO_BASE_REGION) &&
               (addr_view.fields.index < `AO_NUM_PERIPH);

  always_comb begin
    sel_rsp = '{rdata: `AO_DECODE_ERR_DATA, error: 1'b1};
    for (int i = 0; i < `AO_NUM_PERIPH; i++) begin
      valid_vec[i]        = obi_req_i.req && hit && (addr_view.fields.index == 4'(i));
      reg_req_o[i].valid  = valid_vec[i];
      reg_req_o[i].write  = obi_req_i.we;
      reg_req_o[i].be     = obi_req_i.be;
      reg_req_o[i].offset = addr_view.fields.offset;
      reg_req_o[i].wdata  = obi_req_i.wdata;
      if (hit && (addr_view.fields.index == 4'(i))) begin
        sel_rsp = reg_rsp_i[i];
      end
    end
  end

  // Any error, decode or peripheral, reads as the error word
  assign rdata_d = sel_rsp.error ? `AO_DECODE_ERR_DATA : sel_rsp.rdata;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign obi_resp_o.gnt    = obi_req_i.req;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.rdata  = rdata_q;

  // Back-to-back responses need back-to-back requests
  assert property (@(posedge clk_i) disable iff (rst_i)
    obi_resp_o.rvalid && $past(obi_resp_o.rvalid) |-> $past(obi_req_i.req));

  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(valid_vec));

endmodule

//--- rtl/soc_ctrl.sv
/* SoC control registers: program exit value and valid, plus strap readback.
   Sits behind one register-bus port of the bridge. */

`timescale 1ns/1ps

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        boot_select_i,
  input  logic        execute_from_flash_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic        wr_en;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.offset)
        12'h000: if (reg_req_i.be[0]) exit_valid_q <= reg_req_i.wdata[0];
        12'h004: exit_value_q <= apply_be(exit_value_q, reg_req_i.wdata, reg_req_i.be);
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      12'h000: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      12'h004: reg_rsp_o.rdata = exit_value_q;
      12'h008: reg_rsp_o.rdata = {31'b0, boot_select_i};
      12'h00C: reg_rsp_o.rdata = {31'b0, execute_from_flash_i};
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

//--- rtl/rv_timer.sv
/* Machine timer with a prescale tick counter and a sticky compare interrupt.
   MTIME advances once every PRESCALE+1 cycles while enabled. */

`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module rv_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     timer_irq_o
);

  logic        wr_en;
  logic        irq_set;
  logic        ctrl_en_q;
  logic [31:0] prescale_q;
  logic [31:0] tick_q;
  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic        intr_q;

  assign wr_en   = reg_req_i.valid && reg_req_i.write;
  assign irq_set = ctrl_en_q && (mtime_q >= mtimecmp_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_en_q  <= 1'b0;
      prescale_q <= `AO_TIMER_PRESCALE_RST;
      tick_q     <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      intr_q     <= 1'b0;
    end else begin
      // >= so a smaller new prescale cannot strand the counter
      if (ctrl_en_q) begin
        if (tick_q >= prescale_q) begin
          tick_q  <= '0;
          mtime_q <= mtime_q + 32'd1;
        end else begin
          tick_q <= tick_q + 32'd1;
        end
      end
      if (wr_en) begin
        case (reg_req_i.offset)
          12'h000: if (reg_req_i.be[0]) ctrl_en_q <= reg_req_i.wdata[0];
          12'h004: prescale_q <= apply_be(prescale_q, reg_req_i.wdata, reg_req_i.be);
          12'h008: mtime_q <= apply_be(mtime_q, reg_req_i.wdata, reg_req_i.be);
          12'h00C: mtimecmp_q <= apply_be(mtimecmp_q, reg_req_i.wdata, reg_req_i.be);
          default: ;
        endcase
      end
      // Set wins over write-1-to-clear
      if (irq_set) begin
        intr_q <= 1'b1;
      end else if (wr_en && (reg_req_i.offset == 12'h010) && reg_req_i.be[0] &&
                   reg_req_i.wdata[0]) begin
        intr_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      12'h000: reg_rsp_o.rdata = {31'b0, ctrl_en_q};
      12'h004: reg_rsp_o.rdata = prescale_q;
      12'h008: reg_rsp_o.rdata = mtime_q;
      12'h00C: reg_rsp_o.rdata = mtimecmp_q;
      12'h010: reg_rsp_o.rdata = {31'b0, intr_q};
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assign timer_irq_o = intr_q;

  assert property (@(posedge clk_i) disable iff (rst_i) $rose(timer_irq_o) |-> $past(ctrl_en_q));

endmodule

//--- rtl/power_manager.sv
/* CPU power-gate and reset sequencer with its enable and status registers.
   Gates when the core sleeps and wakes it on the timer interrupt. */

`timescale 1ns/1ps

module power_manager
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     timer_irq_i,
  input  logic     core_sleep_i,
  output logic     cpu_powergate_o,
  output logic     cpu_rst_o
);

  logic pwr_en_q;
  logic gated_q;
  logic rst_hold_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pwr_en_q <= 1'b0;
    end else if (reg_req_i.valid && reg_req_i.write && (reg_req_i.offset == 12'h000) &&
                 reg_req_i.be[0]) begin
      pwr_en_q <= reg_req_i.wdata[0];
    end
  end

  // Reset hold trails the gate by one cycle on wake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gated_q    <= 1'b0;
      rst_hold_q <= 1'b0;
    end else begin
      rst_hold_q <= gated_q;
      if (!gated_q && pwr_en_q && core_sleep_i) begin
        gated_q <= 1'b1;
      end else if (gated_q && timer_irq_i) begin
        gated_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      12'h000: reg_rsp_o.rdata = {31'b0, pwr_en_q};
      12'h004: reg_rsp_o.rdata = {31'b0, gated_q};
      default: reg_rsp_o.rdata = '0;
    endcase
  end

  assign cpu_powergate_o = gated_q;
  assign cpu_rst_o       = gated_q | rst_hold_q;

  // Reset covers the gated window and the cycle after power returns
  assert property (@(posedge clk_i) disable iff (rst_i)
    cpu_powergate_o || $fell(cpu_powergate_o) |-> cpu_rst_o);

endmodule

//--- rtl/ao_peripheral_subsystem.sv
/* Always-on peripheral subsystem top: OBI bridge plus SoC control,
   power manager and machine timer on the register bus. */

`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  obi_req_t    obi_req_i,
  output obi_resp_t   obi_resp_o,
  input  logic        boot_select_i,
  input  logic        execute_from_flash_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o,
  input  logic        core_sleep_i,
  output logic        cpu_powergate_o,
  output logic        cpu_rst_o,
  output logic        timer_irq_o
);

  reg_req_t [`AO_NUM_PERIPH-1:0] periph_req;
  reg_rsp_t [`AO_NUM_PERIPH-1:0] periph_rsp;
  logic                          timer_irq;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .rst_i,
    .obi_req_i,
    .obi_resp_o,
    .reg_req_o(periph_req),
    .reg_rsp_i(periph_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_i,
    .reg_req_i(periph_req[`AO_IDX_SOC_CTRL]),
    .reg_rsp_o(periph_rsp[`AO_IDX_SOC_CTRL]),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  power_manager power_manager_i (
    .clk_i,
    .rst_i,
    .reg_req_i(periph_req[`AO_IDX_POWER]),
    .reg_rsp_o(periph_rsp[`AO_IDX_POWER]),
    .timer_irq_i(timer_irq),
    .core_sleep_i,
    .cpu_powergate_o,
    .cpu_rst_o
  );

  rv_timer rv_timer_i (
    .clk_i,
    .rst_i,
    .reg_req_i(periph_req[`AO_IDX_TIMER]),
    .reg_rsp_o(periph_rsp[`AO_IDX_TIMER]),
    .timer_irq_o(timer_irq)
  );

  assign timer_irq_o = timer_irq;

endmodule

//--- testbench/tb_ao_peripheral_subsystem.sv
/* Vector-driven testbench for the always-on peripheral subsystem.
   Reads bus and pin operations from the vector file and checks each response. */

`timescale 1ns/1ps

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
);

  localparam int CLK_PERIOD    = 40;
  localparam int MAX_HANDSHAKE = 8;

  logic        clk;
  logic        rst;
  obi_req_t    obi_req;
  obi_resp_t   obi_resp;
  logic        boot_select;
  logic        exec_flash;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic        core_sleep;
  logic        cpu_powergate;
  logic        cpu_rst;
  logic        timer_irq;

  string       op_q[$];
  string       name_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0]  be_q[$];
  logic [31:0] exp_q[$];
  int          budget_q[$];
  int          total_budget;
  bit          loaded;
  int          errors;
  int          checks;

  ao_peripheral_subsystem u_dut (
    .clk_i(clk),
    .rst_i(rst),
    .obi_req_i(obi_req),
    .obi_resp_o(obi_resp),
    .boot_select_i(boot_select),
    .execute_from_flash_i(exec_flash),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value),
    .core_sleep_i(core_sleep),
    .cpu_powergate_o(cpu_powergate),
    .cpu_rst_o(cpu_rst),
    .timer_irq_o(timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       op;
    string       name;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic [31:0] exp;
    int          budget;
    fd = $fopen("testbench/ao_periph_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("ERROR: cannot open testbench/ao_periph_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") continue;
        n = $sscanf(line, "%s %s %h %h %h %h %d", op, name, addr, data, be, exp, budget);
        if (n != 7) begin
          errors++;
          $display("ERROR: malformed vector line: %s", line);
          continue;
        end
        op_q.push_back(op);
        name_q.push_back(name);
        addr_q.push_back(addr);
        data_q.push_back(data);
        be_q.push_back(be);
        exp_q.push_back(exp);
        budget_q.push_back(budget);
        total_budget += budget;
      end
      $fclose(fd);
    end
  endtask

  // One OBI access; returns at the falling edge of the response cycle
  task automatic bus_access(input string name, input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata);
    int waited;
    rdata = 'x;
    @(posedge clk);
    #2;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    @(negedge clk);
    waited = 0;
    while (!obi_resp.gnt && waited < MAX_HANDSHAKE) begin
      @(negedge clk);
      waited++;
    end
    if (!obi_resp.gnt) begin
      errors++;
      $display("ERROR: %s: no grant within %0d cycles", name, MAX_HANDSHAKE);
    end
    @(posedge clk);
    #2;
    obi_req = '0;
    @(negedge clk);
    waited = 0;
    while (!obi_resp.rvalid && waited < MAX_HANDSHAKE) begin
      @(negedge clk);
      waited++;
    end
    if (!obi_resp.rvalid) begin
      errors++;
      $display("ERROR: %s: no read-valid response within %0d cycles", name, MAX_HANDSHAKE);
    end else begin
      rdata = obi_resp.rdata;
    end
  endtask

  task automatic run_line(input int i);
    logic [31:0] rd;
    logic [31:0] exp;
    logic [31:0] rnd;
    logic [3:0]  pins;
    logic [1:0]  pair;
    int          waited;
    exp = exp_q[i];
    if (op_q[i] == "write") begin
      bus_access(name_q[i], 1'b1, addr_q[i], data_q[i], be_q[i], rd);
    end else if (op_q[i] == "read") begin
      bus_access(name_q[i], 1'b0, addr_q[i], 32'd0, be_q[i], rd);
      checks++;
      // Strap reads expect whatever was driven on the pin
      if (data_q[i] == 32'd1) exp = {31'b0, boot_select};
      if (data_q[i] == 32'd2) exp = {31'b0, exec_flash};
      if (data_q[i] == 32'd3) begin
        if (rd < exp) report_mismatch($sformatf("%s (minimum)", name_q[i]), exp, rd);
      end else if (rd !== exp) begin
        report_mismatch(name_q[i], exp, rd);
      end
    end else if (op_q[i] == "pins") begin
      case (addr_q[i])
        32'd0: begin
          @(posedge clk);
          #2;
          rnd         = $urandom;
          boot_select = rnd[0];
          exec_flash  = rnd[1];
          @(negedge clk);
        end
        32'd1: begin
          @(posedge clk);
          #2;
          core_sleep = data_q[i][0];
          @(negedge clk);
        end
        32'd2: begin
          checks++;
          if (exit_value !== exp) report_mismatch(name_q[i], exp, exit_value);
        end
        32'd3: begin
          pins = {timer_irq, cpu_rst, cpu_powergate, exit_valid};
          checks++;
          if (pins !== exp[3:0]) report_mismatch(name_q[i], {28'b0, exp[3:0]}, {28'b0, pins});
        end
        default: begin
          errors++;
          $display("ERROR: %s: unknown pin group %h", name_q[i], addr_q[i]);
        end
      endcase
    end else if (op_q[i] == "sleep_check") begin
      for (int k = 0; k < int'(data_q[i]); k++) begin
        if (k > 0) @(negedge clk);
        pair = {cpu_rst, cpu_powergate};
        checks++;
        if (pair !== exp[4*k+:2]) begin
          report_mismatch($sformatf("%s cycle %0d", name_q[i], k), {30'b0, exp[4*k+:2]},
                          {30'b0, pair});
        end
      end
    end else if (op_q[i] == "wait_irq") begin
      waited = 0;
      while (!timer_irq && waited < budget_q[i]) begin
        @(negedge clk);
        waited++;
      end
      checks++;
      if (!timer_irq) begin
        errors++;
        $display("ERROR: %s: timer interrupt did not arrive within %0d cycles", name_q[i],
                 budget_q[i]);
      end
    end else begin
      errors++;
      $display("ERROR: unknown operation %s on line %0d", op_q[i], i);
    end
  endtask

  initial begin : watchdog
    wait (loaded);
    #((total_budget + 200) * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles", total_budget + 200);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(41811));
    rst          = 1'b1;
    obi_req      = '0;
    boot_select  = 1'b0;
    exec_flash   = 1'b0;
    core_sleep   = 1'b0;
    errors       = 0;
    checks       = 0;
    total_budget = 0;
    loaded       = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    checks++;
    if (obi_resp.rvalid !== 1'b0) report_mismatch("rst_rvalid", 32'd0, {31'b0, obi_resp.rvalid});
    for (int i = 0; i < op_q.size(); i++) begin
      run_line(i);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- testbench/ao_periph_vectors.txt
# op test addr data be expected budget(cycles; max wait for wait_irq)
# read data: 0 equal, 1 boot strap, 2 flash strap, 3 at least expected
# pins addr: 0 random straps, 1 core_sleep_i=data, 2 exit_value_o, 3 {irq,rst,gate,exit_valid}
# sleep_check: data cycles, expected nibble {cpu_rst,powergate} per cycle, lowest first
pins        rst_outputs      00000003 0        0 00000000 2
pins        rst_exit_value   00000002 0        0 00000000 2
read        rst_prescale     20002004 0        f 00000003 10
read        rst_mtimecmp     2000200c 0        f ffffffff 10
pins        strap_draw_a     00000000 0        0 00000000 2
read        strap_boot_a     20000008 1        f 00000000 10
read        strap_flash_a    2000000c 2        f 00000000 10
pins        strap_draw_b     00000000 0        0 00000000 2
read        strap_boot_b     20000008 1        f 00000000 10
read        strap_flash_b    2000000c 2        f 00000000 10
write       exit_value_full  20000004 a5a5a5a5 f 00000000 10
write       exit_value_low   20000004 00001234 3 00000000 10
read        exit_value_merge 20000004 0        f a5a51234 10
write       exit_valid_set   20000000 1        1 00000000 10
pins        exit_valid_pin   00000003 0        0 00000001 2
pins        exit_value_pin   00000002 0        0 a5a51234 2
read        dec_region       30000004 0        f badcab1e 10
read        dec_index        20003000 0        f badcab1e 10
write       dec_region_wr    30000004 ffffffff f 00000000 10
write       dec_index_wr     20003004 ffffffff f 00000000 10
read        dec_exit_keep    20000004 0        f a5a51234 10
write       tmr_prescale     20002004 1        f 00000000 10
write       tmr_mtime        20002008 0        f 00000000 10
write       tmr_cmp          2000200c a        f 00000000 10
write       tmr_enable       20002000 1        1 00000000 10
wait_irq    tmr_irq          00000000 0        0 00000000 60
read        tmr_mtime_rd     20002008 3        f 0000000a 10
write       tmr_disable      20002000 0        1 00000000 10
write       tmr_clear        20002010 1        1 00000000 10
read        tmr_status_rd    20002010 0        f 00000000 10
pins        tmr_irq_pin      00000003 0        0 00000001 2
write       pwr_enable       20001000 1        1 00000000 10
pins        pwr_sleep_on     00000001 1        0 00000000 2
sleep_check pwr_gate         00000000 2        0 00000030 4
pins        pwr_sleep_off    00000001 0        0 00000000 2
read        pwr_status_on    20001004 0        f 00000001 10
write       wake_mtime       20002008 0        f 00000000 10
write       wake_cmp         2000200c 5        f 00000000 10
write       wake_enable      20002000 1        1 00000000 10
wait_irq    wake_irq         00000000 0        0 00000000 40
sleep_check wake_seq         00000000 3        0 00000023 4
read        pwr_status_off   20001004 0        f 00000000 10

//--- files.f
+incdir+include
rtl/ao_periph_pkg.sv
rtl/obi_reg_bridge.sv
rtl/soc_ctrl.sv
rtl/rv_timer.sv
rtl/power_manager.sv
rtl/ao_peripheral_subsystem.sv
testbench/tb_ao_peripheral_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and grade the log
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_ao_peripheral_subsystem
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module "$TOP" \
  -Mdir "$BUILD_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
  echo "Simulation log has no final status"
  exit 1
fi
exit 0
